//--- design/mul_pkg.sv
/*
  Shared types and sizes for the shared multiply unit.
  QUEUE_DEPTH must stay at 2 or more. XLEN is fixed at 32 by the MULH datapath.
*/
package mul_pkg;

  // Operand width
  localparam int unsigned XLEN = 32;

  // Number of requesters sharing the unit
  localparam int unsigned NUM_PORTS = 2;

  // Entries in each issue queue
  localparam int unsigned QUEUE_DEPTH = 2;
  // Pointer and occupancy widths derived from the depth
  localparam int unsigned QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int unsigned QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

  // Bit positions inside the 2-bit signed mode
  // Set bit means the operand is treated as signed
  localparam int unsigned SIGNED_A_BIT = 0;
  localparam int unsigned SIGNED_B_BIT = 1;

  // Operation select
  typedef enum logic {
    MUL_M32 = 1'b0, // low word, single cycle
    MUL_H   = 1'b1  // high word, four cycles
  } mul_opcode_e;

  // MULH sequencer states
  // MUL_ALBL doubles as the idle state
  typedef enum logic [1:0] {
    MUL_ALBL = 2'b00,
    MUL_ALBH = 2'b01,
    MUL_AHBL = 2'b10,
    MUL_AHBH = 2'b11
  } mul_state_e;

endpackage

//--- design/mul_req_if.sv
/*
  One request/response channel. Request fields must hold while req_valid is
  high, and a request completes only together with its response.
*/
`timescale 1ns/100ps

interface mul_req_if import mul_pkg::*; ();

  // Request side
  logic              req_valid;
  logic              req_ready;
  mul_opcode_e       operator;
  logic [1:0]        signed_mode;
  logic [XLEN-1:0]   op_a;
  logic [XLEN-1:0]   op_b;

  // Response side
  logic              rsp_valid;
  logic              rsp_ready;
  logic [XLEN-1:0]   result;

  // Side that issues operations
  modport requester (
    output req_valid, operator, signed_mode, op_a, op_b, rsp_ready,
    input  req_ready, rsp_valid, result
  );

  // Side that executes operations
  modport server (
    input  req_valid, operator, signed_mode, op_a, op_b, rsp_ready,
    output req_ready, rsp_valid, result
  );

endinterface

//--- design/mul_unit.sv
/*
  MUL answers in the cycle it is presented. MULH takes four cycles and needs
  stable operands throughout; dropping req_valid aborts it with no response.
*/
`timescale 1ns/100ps

module mul_unit import mul_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  mul_req_if.server srv
);

  // Operands to the shared signed multiplier
  logic [XLEN-1:0] mul_a;
  logic [XLEN-1:0] mul_b;
  logic [33:0]     int_result;

  // Half-word partial operands, 17 bits with sign slot
  logic [16:0]     part_al;
  logic [16:0]     part_bl;
  logic [16:0]     part_ah;
  logic [16:0]     part_bh;
  logic [16:0]     part_a;
  logic [16:0]     part_b;

  // Sequencer
  mul_state_e      state_q;
  mul_state_e      state_d;
  logic            acc_shift;

  // Accumulator and adder
  logic [32:0]     acc_q;
  logic [32:0]     acc_d;
  logic [32:0]     acc_res;
  logic [33:0]     sum;
  logic [33:0]     sum_shifted;

  //////////////////////////////////////////////////
  // Partial operands
  //////////////////////////////////////////////////

  // Low halves are always unsigned
  assign part_al = {1'b0, srv.op_a[15:0]};
  assign part_bl = {1'b0, srv.op_b[15:0]};

  // High halves carry the operand sign only in signed mode
  assign part_ah = {srv.signed_mode[SIGNED_A_BIT] & srv.op_a[XLEN-1], srv.op_a[31:16]};
  assign part_bh = {srv.signed_mode[SIGNED_B_BIT] & srv.op_b[XLEN-1], srv.op_b[31:16]};

  //////////////////////////////////////////////////
  // MULH sequencer
  //////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    acc_d         = '0;
    acc_shift     = 1'b0;
    part_a        = part_al;
    part_b        = part_bl;
    srv.req_ready = 1'b0;
    srv.rsp_valid = 1'b0;

    case (state_q)
      MUL_ALBL: begin
        if (srv.req_valid) begin
          if (srv.operator == MUL_H) begin
            // Start with low x low, keep only its upper part
            acc_shift = 1'b1;
            acc_d     = acc_res;
            state_d   = MUL_ALBH;
          end else begin
            // Single cycle, completes when the response is taken
            srv.rsp_valid = 1'b1;
            srv.req_ready = srv.rsp_ready;
          end
        end else begin
          srv.req_ready = 1'b1;
        end
      end

      MUL_ALBH: begin
        part_a = part_al;
        part_b = part_bh;
        // Abort leaves acc_d cleared
        if (srv.req_valid) begin
          acc_d   = acc_res;
          state_d = MUL_AHBL;
        end else begin
          state_d = MUL_ALBL;
        end
      end

      MUL_AHBL: begin
        part_a    = part_ah;
        part_b    = part_bl;
        acc_shift = 1'b1;
        if (srv.req_valid) begin
          acc_d   = acc_res;
          state_d = MUL_AHBH;
        end else begin
          state_d = MUL_ALBL;
        end
      end

      MUL_AHBH: begin
        part_a = part_ah;
        part_b = part_bh;
        if (srv.req_valid) begin
          // Result ready, accumulator frozen until taken
          srv.rsp_valid = 1'b1;
          srv.req_ready = srv.rsp_ready;
          acc_d         = acc_q;
          if (srv.rsp_ready) begin
            acc_d   = '0;
            state_d = MUL_ALBL;
          end
        end else begin
          state_d = MUL_ALBL;
        end
      end

      default: state_d = MUL_ALBL;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MUL_ALBL;
      acc_q   <= '0;
    end else begin
      state_q <= state_d;
      acc_q   <= acc_d;
    end
  end

  //////////////////////////////////////////////////
  // Shared multiplier and accumulate
  //////////////////////////////////////////////////

  // Full operands for MUL, sign-extended 17-bit halves for MULH
  assign mul_a = (srv.operator == MUL_M32) ? srv.op_a : {{15{part_a[16]}}, part_a};
  assign mul_b = (srv.operator == MUL_M32) ? srv.op_b : {{15{part_b[16]}}, part_b};

  assign int_result = $signed({{2{mul_a[XLEN-1]}}, mul_a}) *
                      $signed({{2{mul_b[XLEN-1]}}, mul_b});

  // Accumulator is zero in MUL_ALBL, so MUL passes straight through
  assign sum         = $signed(int_result) + $signed({acc_q[32], acc_q});
  assign sum_shifted = $signed(sum) >>> 16;
  assign acc_res     = acc_shift ? sum_shifted[32:0] : sum[32:0];

  assign srv.result = sum[XLEN-1:0];

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Only MULH may occupy the multicycle states
  a_mulh_only: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q != MUL_ALBL && srv.req_valid) |-> srv.operator == MUL_H);

  // Queue and arbiter must keep the operands fixed across the sequence
  a_ops_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q != MUL_ALBL && srv.req_valid) |-> ($stable(srv.op_a) && $stable(srv.op_b)));

endmodule

//--- design/mul_issue_queue.sv
/*
  Two-entry request FIFO in front of one requester. The head is popped only
  when its response transfers. Kill drops every entry, including one in flight.
*/
`timescale 1ns/100ps

module mul_issue_queue import mul_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  mul_opcode_e       operator_i,
  input  logic [1:0]        signed_mode_i,
  input  logic [XLEN-1:0]   op_a_i,
  input  logic [XLEN-1:0]   op_b_i,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output logic [XLEN-1:0]   result_o,
  input  logic              kill_i,
  mul_req_if.requester      mq
);

  // Entry storage
  mul_opcode_e            op_mem   [QUEUE_DEPTH];
  logic [1:0]             mode_mem [QUEUE_DEPTH];
  logic [XLEN-1:0]        a_mem    [QUEUE_DEPTH];
  logic [XLEN-1:0]        b_mem    [QUEUE_DEPTH];

  // Pointers and occupancy
  logic [QUEUE_PTR_W-1:0] wr_ptr_q;
  logic [QUEUE_PTR_W-1:0] rd_ptr_q;
  logic [QUEUE_CNT_W-1:0] count_q;
  logic                   push;
  logic                   pop;

  // Accept while not full and not being flushed
  assign req_ready_o = (count_q != QUEUE_CNT_W'(QUEUE_DEPTH)) && !kill_i;
  assign push        = req_valid_i && req_ready_o;
  // Pop on response transfer
  assign pop         = mq.rsp_valid && mq.rsp_ready;

  // Head presented to the arbiter, hidden during kill so MULH aborts
  assign mq.req_valid   = (count_q != '0) && !kill_i;
  assign mq.operator    = op_mem[rd_ptr_q];
  assign mq.signed_mode = mode_mem[rd_ptr_q];
  assign mq.op_a        = a_mem[rd_ptr_q];
  assign mq.op_b        = b_mem[rd_ptr_q];

  // Response path, masked while killed
  assign mq.rsp_ready = rsp_ready_i && !kill_i;
  assign rsp_valid_o  = mq.rsp_valid && !kill_i;
  assign result_o     = mq.result;

  always_ff @(posedge clk) begin
    if (push) begin
      op_mem[wr_ptr_q]   <= operator_i;
      mode_mem[wr_ptr_q] <= signed_mode_i;
      a_mem[wr_ptr_q]    <= op_a_i;
      b_mem[wr_ptr_q]    <= op_b_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (kill_i) begin
      // Flush everything
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> count_q < QUEUE_CNT_W'(QUEUE_DEPTH));

  // A response must close a request that this queue actually holds
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> (count_q != '0) && mq.req_ready);

endmodule

//--- design/mul_rr_arbiter.sv
/*
  Round-robin between two queues. The grant is locked from first presentation
  until the response transfers or the granted valid drops.
*/
`timescale 1ns/100ps

module mul_rr_arbiter import mul_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  mul_req_if.server     req0,
  mul_req_if.server     req1,
  mul_req_if.requester  unit
);

  // One-hot grant that is all zero when nothing is requested
  logic [NUM_PORTS-1:0] req_vec;
  logic [NUM_PORTS-1:0] grant;
  logic [NUM_PORTS-1:0] grant_q;
  logic                 locked_q;
  // Set means port 1 is looked at first
  logic                 prio_q;
  logic                 rsp_fire;
  logic                 op_end;

  assign req_vec  = {req1.req_valid, req0.req_valid};
  assign rsp_fire = unit.rsp_valid && unit.rsp_ready;

  // Grant selection
  always_comb begin
    if (locked_q) begin
      grant = grant_q;
    end else if (prio_q) begin
      grant = req_vec[1] ? 2'b10 : {1'b0, req_vec[0]};
    end else begin
      grant = req_vec[0] ? 2'b01 : {req_vec[1], 1'b0};
    end
  end

  // Request mux toward the unit
  assign unit.req_valid   = |(grant & req_vec);
  assign unit.operator    = grant[1] ? req1.operator    : req0.operator;
  assign unit.signed_mode = grant[1] ? req1.signed_mode : req0.signed_mode;
  assign unit.op_a        = grant[1] ? req1.op_a        : req0.op_a;
  assign unit.op_b        = grant[1] ? req1.op_b        : req0.op_b;
  assign unit.rsp_ready   = (grant[0] && req0.rsp_ready) || (grant[1] && req1.rsp_ready);

  // Return path goes only to the granted queue
  assign req0.req_ready = grant[0] && unit.req_ready;
  assign req0.rsp_valid = grant[0] && unit.rsp_valid;
  assign req0.result    = grant[0] ? unit.result : '0;
  assign req1.req_ready = grant[1] && unit.req_ready;
  assign req1.rsp_valid = grant[1] && unit.rsp_valid;
  assign req1.result    = grant[1] ? unit.result : '0;

  // Operation ends on response or on abort while locked
  assign op_end = locked_q ? (!unit.req_valid || rsp_fire) : rsp_fire;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      locked_q <= 1'b0;
      grant_q  <= '0;
      prio_q   <= 1'b0;
    end else begin
      // Hold through a multicycle op and release one cycle after valid drops
      locked_q <= unit.req_valid && !rsp_fire;
      grant_q  <= grant;
      if (op_end) begin
        // Served port goes to the back
        prio_q <= grant[0];
      end
    end
  end

  // A port still presenting an unfinished operation keeps the grant
  a_grant_held: assert property (@(posedge clk) disable iff (!rst_n)
    (unit.req_valid && !rsp_fire) |=>
      (!(|($past(grant) & req_vec)) || grant == $past(grant)));

  a_one_rsp: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({req1.rsp_valid, req0.rsp_valid}));

endmodule

//--- design/mul_shared_top.sv
/*
  Two requesters share one multiply unit. Responses are in order per port.
  Kill drops all queued and in-flight work of that port without a response.
*/
`timescale 1ns/100ps

module mul_shared_top import mul_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,

  // Port 0
  input  logic            p0_req_valid_i,
  output logic            p0_req_ready_o,
  input  mul_opcode_e     p0_operator_i,
  input  logic [1:0]      p0_signed_mode_i,
  input  logic [XLEN-1:0] p0_op_a_i,
  input  logic [XLEN-1:0] p0_op_b_i,
  output logic            p0_rsp_valid_o,
  input  logic            p0_rsp_ready_i,
  output logic [XLEN-1:0] p0_result_o,
  input  logic            p0_kill_i,

  // Port 1
  input  logic            p1_req_valid_i,
  output logic            p1_req_ready_o,
  input  mul_opcode_e     p1_operator_i,
  input  logic [1:0]      p1_signed_mode_i,
  input  logic [XLEN-1:0] p1_op_a_i,
  input  logic [XLEN-1:0] p1_op_b_i,
  output logic            p1_rsp_valid_o,
  input  logic            p1_rsp_ready_i,
  output logic [XLEN-1:0] p1_result_o,
  input  logic            p1_kill_i
);

  // Queue heads into the arbiter, arbiter into the unit
  mul_req_if q0_if ();
  mul_req_if q1_if ();
  mul_req_if unit_if ();

  mul_issue_queue u_q0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (p0_req_valid_i),
    .req_ready_o   (p0_req_ready_o),
    .operator_i    (p0_operator_i),
    .signed_mode_i (p0_signed_mode_i),
    .op_a_i        (p0_op_a_i),
    .op_b_i        (p0_op_b_i),
    .rsp_valid_o   (p0_rsp_valid_o),
    .rsp_ready_i   (p0_rsp_ready_i),
    .result_o      (p0_result_o),
    .kill_i        (p0_kill_i),
    .mq            (q0_if.requester)
  );

  mul_issue_queue u_q1 (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (p1_req_valid_i),
    .req_ready_o   (p1_req_ready_o),
    .operator_i    (p1_operator_i),
    .signed_mode_i (p1_signed_mode_i),
    .op_a_i        (p1_op_a_i),
    .op_b_i        (p1_op_b_i),
    .rsp_valid_o   (p1_rsp_valid_o),
    .rsp_ready_i   (p1_rsp_ready_i),
    .result_o      (p1_result_o),
    .kill_i        (p1_kill_i),
    .mq            (q1_if.requester)
  );

  mul_rr_arbiter u_arb (
    .clk   (clk),
    .rst_n (rst_n),
    .req0  (q0_if.server),
    .req1  (q1_if.server),
    .unit  (unit_if.requester)
  );

  mul_unit u_unit (
    .clk   (clk),
    .rst_n (rst_n),
    .srv   (unit_if.server)
  );

endmodule

//--- test/tb_clk_gen.sv
/* Free-running clock with an 8 ns period, starting low */
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o
);

  localparam int HALF_PERIOD_NS = 4;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

endmodule

//--- test/mul_shared_tb.sv
/*
  Drives both ports of the shared multiplier and checks every response against
  a reference model, in per-port order. Requests per port must stay below 1024.
*/
`timescale 1ns/100ps

module mul_shared_tb import mul_pkg::*; ();

  localparam int RND_N           = 100;
  localparam int BP_N            = 60;
  localparam int KILL_N          = 20;
  localparam int RND_TOTAL       = RND_N + BP_N + KILL_N;
  // Requests of the directed, mixed, fill, back-pressure and kill phases
  localparam int NUM_REQ         = 125 + 2 * RND_N + 2 + 2 * BP_N + 3 + KILL_N;
  localparam int WATCHDOG_CYCLES = NUM_REQ * 20 + 300;
  localparam int EXP_DEPTH       = 1024;

  logic        clk;
  logic        rst_n;
  logic        req_valid [2];
  logic        req_ready [2];
  mul_opcode_e req_op    [2];
  logic [1:0]  req_mode  [2];
  logic [31:0] req_a     [2];
  logic [31:0] req_b     [2];
  logic        rsp_valid [2];
  logic        rsp_ready [2];
  logic [31:0] result    [2];
  logic        kill      [2];

  // Stimulus control
  logic        rsp_hold  [2];
  logic        bp_en;
  logic [31:0] corner    [5];

  // Random traffic drawn before any port starts
  logic        rnd_op    [2][RND_TOTAL];
  logic [1:0]  rnd_mode  [2][RND_TOTAL];
  logic [31:0] rnd_a     [2][RND_TOTAL];
  logic [31:0] rnd_b     [2][RND_TOTAL];

  // Expected results in one ring per port
  logic [31:0] exp_mem   [2][EXP_DEPTH];
  int          exp_head  [2] = '{0, 0};
  int          exp_tail  [2] = '{0, 0};
  int          mon_errors = 0;
  int          seq_errors = 0;
  int          n_checked  = 0;

  tb_clk_gen u_clk (.clk_o(clk));

  mul_shared_top mul_shared_top_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .p0_req_valid_i   (req_valid[0]),
    .p0_req_ready_o   (req_ready[0]),
    .p0_operator_i    (req_op[0]),
    .p0_signed_mode_i (req_mode[0]),
    .p0_op_a_i        (req_a[0]),
    .p0_op_b_i        (req_b[0]),
    .p0_rsp_valid_o   (rsp_valid[0]),
    .p0_rsp_ready_i   (rsp_ready[0]),
    .p0_result_o      (result[0]),
    .p0_kill_i        (kill[0]),
    .p1_req_valid_i   (req_valid[1]),
    .p1_req_ready_o   (req_ready[1]),
    .p1_operator_i    (req_op[1]),
    .p1_signed_mode_i (req_mode[1]),
    .p1_op_a_i        (req_a[1]),
    .p1_op_b_i        (req_b[1]),
    .p1_rsp_valid_o   (rsp_valid[1]),
    .p1_rsp_ready_i   (rsp_ready[1]),
    .p1_result_o      (result[1]),
    .p1_kill_i        (kill[1])
  );

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Mode bit 0 signs op_a and bit 1 signs op_b
  function automatic logic [31:0] ref_mul(input mul_opcode_e op, input logic [1:0] mode,
                                          input logic [31:0] a, input logic [31:0] b);
    logic signed [65:0] ext_a;
    logic signed [65:0] ext_b;
    logic signed [65:0] prod;
    ext_a = {{34{mode[0] & a[31]}}, a};
    ext_b = {{34{mode[1] & b[31]}}, b};
    prod  = ext_a * ext_b;
    return (op == MUL_M32) ? prod[31:0] : prod[63:32];
  endfunction

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////

  // Present one request and hold it until the queue takes it
  task automatic send_req(input int p, input mul_opcode_e op, input logic [1:0] mode,
                          input logic [31:0] a, input logic [31:0] b);
    @(posedge clk);
    #1;
    req_valid[p] = 1'b1;
    req_op[p]    = op;
    req_mode[p]  = mode;
    req_a[p]     = a;
    req_b[p]     = b;
    @(negedge clk);
    while (!req_ready[p]) @(negedge clk);
    @(posedge clk);
    #1;
    req_valid[p] = 1'b0;
  endtask

  task automatic run_random(input int p, input int first, input int count);
    for (int i = first; i < first + count; i++) begin
      send_req(p, mul_opcode_e'(rnd_op[p][i]), rnd_mode[p][i], rnd_a[p][i], rnd_b[p][i]);
    end
  endtask

  // Wait until every accepted request has been answered
  task automatic wait_drain();
    @(negedge clk);
    while (exp_head[0] != exp_tail[0] || exp_head[1] != exp_tail[1]) @(negedge clk);
  endtask

  // Response ready per port and random under back-pressure
  initial begin
    rsp_ready[0] = 1'b1;
    rsp_ready[1] = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      for (int p = 0; p < 2; p++) begin
        if (rsp_hold[p]) rsp_ready[p] = 1'b0;
        else if (bp_en) rsp_ready[p] = ($urandom % 4) != 0;
        else rsp_ready[p] = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Compare process sampling mid-cycle
  //////////////////////////////////////////////////

  always @(negedge clk) begin : compare
    logic [31:0] exp_val;
    if (rst_n) begin
      for (int p = 0; p < 2; p++) begin
        if (kill[p]) begin
          // Flushed work never answers
          exp_head[p] = exp_tail[p];
        end else begin
          if (rsp_valid[p] && rsp_ready[p]) begin
            assert (exp_head[p] != exp_tail[p]) else begin
              $display("Port %0d gave a response at %0t with nothing outstanding", p, $time);
              mon_errors++;
            end
            if (exp_head[p] != exp_tail[p]) begin
              exp_val = exp_mem[p][exp_head[p] % EXP_DEPTH];
              exp_head[p]++;
              n_checked++;
              assert (result[p] == exp_val) else begin
                $display("ERR t=%0t p%0d_result_o exp=%08h got=%08h",
                         $time, p, exp_val, result[p]);
                mon_errors++;
              end
            end
          end
          if (req_valid[p] && req_ready[p]) begin
            exp_mem[p][exp_tail[p] % EXP_DEPTH] =
              ref_mul(req_op[p], req_mode[p], req_a[p], req_b[p]);
            exp_tail[p]++;
          end
        end
      end
    end
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, outstanding p0=%0d p1=%0d, errors=%0d",
             WATCHDOG_CYCLES, exp_tail[0] - exp_head[0], exp_tail[1] - exp_head[1],
             mon_errors + seq_errors);
    $display("TEST FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h9cca5f65));
    rst_n    = 1'b0;
    bp_en    = 1'b0;
    corner   = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    for (int p = 0; p < 2; p++) begin
      req_valid[p] = 1'b0;
      req_op[p]    = MUL_M32;
      req_mode[p]  = 2'b00;
      req_a[p]     = '0;
      req_b[p]     = '0;
      kill[p]      = 1'b0;
      rsp_hold[p]  = 1'b0;
      for (int i = 0; i < RND_TOTAL; i++) begin
        rnd_op[p][i]   = 1'($urandom % 2);
        rnd_mode[p][i] = 2'($urandom % 4);
        // Corner operands now and then
        rnd_a[p][i]    = ($urandom % 8 == 0) ? corner[$urandom % 5] : $urandom;
        rnd_b[p][i]    = ($urandom % 8 == 0) ? corner[$urandom % 5] : $urandom;
      end
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Reset state
    @(negedge clk);
    for (int p = 0; p < 2; p++) begin
      assert (!rsp_valid[p]) else begin
        $display("ERR t=%0t p%0d_rsp_valid_o exp=0 got=%b", $time, p, rsp_valid[p]);
        seq_errors++;
      end
      assert (req_ready[p]) else begin
        $display("ERR t=%0t p%0d_req_ready_o exp=1 got=%b", $time, p, req_ready[p]);
        seq_errors++;
      end
    end

    // Directed corners on port 0 with MUL and then MULH in every mode
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 5; j++) begin
        send_req(0, MUL_M32, 2'b00, corner[i], corner[j]);
        for (int m = 0; m < 4; m++) begin
          send_req(0, MUL_H, 2'(m), corner[i], corner[j]);
        end
      end
    end
    wait_drain();

    // Both ports at once
    fork
      run_random(0, 0, RND_N);
      run_random(1, 0, RND_N);
    join
    wait_drain();

    // Port 1 fills with no response taken
    rsp_hold[1] = 1'b1;
    send_req(1, MUL_H, 2'b01, 32'h1234_5678, 32'hfedc_ba98);
    send_req(1, MUL_M32, 2'b00, 32'h0000_ffff, 32'h0001_0001);
    @(negedge clk);
    assert (!req_ready[1]) else begin
      $display("Port 1 still accepted requests with two outstanding at %0t", $time);
      seq_errors++;
    end
    rsp_hold[1] = 1'b0;

    // Random back-pressure on both ports
    bp_en = 1'b1;
    fork
      run_random(0, RND_N, BP_N);
      run_random(1, RND_N, BP_N);
    join
    wait_drain();
    bp_en = 1'b0;

    // Kill port 0 with a MULH in flight and a MUL queued
    fork
      begin
        rsp_hold[0] = 1'b1;
        send_req(0, MUL_H, 2'b11, 32'h8000_0001, 32'h7fff_fffe);
        send_req(0, MUL_M32, 2'b00, 32'h0000_0003, 32'h0000_0005);
        @(posedge clk);
        #1;
        kill[0] = 1'b1;
        @(posedge clk);
        #1;
        kill[0] = 1'b0;
        @(negedge clk);
        rsp_hold[0] = 1'b0;
        send_req(0, MUL_H, 2'b10, 32'hdead_beef, 32'h1357_9bdf);
      end
      run_random(1, RND_N + BP_N, KILL_N);
    join
    wait_drain();
    repeat (4) @(posedge clk);

    $display("Responses checked: %0d, compare errors: %0d, sequence errors: %0d",
             n_checked, mon_errors, seq_errors);
    if (mon_errors + seq_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- mul_shared_top.f
design/mul_pkg.sv
design/mul_req_if.sv
design/mul_unit.sv
design/mul_issue_queue.sv
design/mul_rr_arbiter.sv
design/mul_shared_top.sv
test/tb_clk_gen.sv
test/mul_shared_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the shared multiplier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module mul_shared_tb -Mdir obj_dir -f mul_shared_top.f

sim_out=$(./obj_dir/Vmul_shared_tb)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1
